// File: hw/simd_alu_config.svh
/*
 * Datapath sizing of the SIMD ALU
 * Word width, byte count and input-to-output latency
 */

`ifndef SIMD_ALU_CONFIG_SVH
`define SIMD_ALU_CONFIG_SVH

////////////////////////////////////////////////////////////////////////////
// Datapath
////////////////////////////////////////////////////////////////////////////

// Operand and result width
`define SIMD_ALU_DATA_W 64

// One saturation flag per byte
`define SIMD_ALU_STRB_W (`SIMD_ALU_DATA_W / 8)

////////////////////////////////////////////////////////////////////////////
// Pipeline
////////////////////////////////////////////////////////////////////////////

// Decode, lane execute, result
`define SIMD_ALU_LATENCY 3

`endif

// File: hw/simd_alu_decode.sv
/*
 * Stage 1 of the SIMD ALU
 * Operation decode into control flags, registered with the operands
 */
`timescale 1ns/1ns

module simd_alu_decode import simd_alu_pkg::*; (
  input  logic         clk_i,
  input  logic         arst_n_i,
  input  logic         valid_i,
  input  alu_op_e      op_i,
  input  elem_width_e  ew_i,
  input  alu_word_u    operand_a_i,
  input  alu_word_u    operand_b_i,
  output decode_ctrl_t ctrl_o
);

  decode_ctrl_t ctrl_d;

  always_comb begin : p_decode
    ctrl_d       = '0;
    ctrl_d.valid = valid_i;
    ctrl_d.ew    = ew_i;
    ctrl_d.opa   = operand_a_i;
    ctrl_d.opb   = operand_b_i;

    unique case (op_i)
      ALU_AND, ALU_OR, ALU_XOR:                ctrl_d.res_sel = SEL_LOGIC;
      ALU_SLL, ALU_SRL, ALU_SRA:               ctrl_d.res_sel = SEL_SHIFT;
      ALU_MIN, ALU_MINU, ALU_MAX, ALU_MAXU:    ctrl_d.res_sel = SEL_MINMAX;
      ALU_MSEQ, ALU_MSLT, ALU_MSLTU:           ctrl_d.res_sel = SEL_CMP;
      default:                                 ctrl_d.res_sel = SEL_ARITH;
    endcase

    unique case (op_i)
      ALU_SADDU: ctrl_d.sat_kind = SAT_UADD;
      ALU_SADD:  ctrl_d.sat_kind = SAT_SADD;
      ALU_SSUBU: ctrl_d.sat_kind = SAT_USUB;
      ALU_SSUB:  ctrl_d.sat_kind = SAT_SSUB;
      default:   ctrl_d.sat_kind = SAT_NONE;
    endcase

    ctrl_d.is_signed = op_i inside {ALU_MIN, ALU_MAX, ALU_MSLT};
    ctrl_d.is_sub    = op_i inside {ALU_SUB, ALU_RSUB, ALU_SSUBU, ALU_SSUB};
    ctrl_d.is_rsub   = op_i == ALU_RSUB;
    ctrl_d.pick_max  = op_i inside {ALU_MAX, ALU_MAXU};
    ctrl_d.logic_fn  = (op_i == ALU_OR) ? 2'd1 : (op_i == ALU_XOR) ? 2'd2 : 2'd0;
    ctrl_d.shift_fn  = (op_i == ALU_SRL) ? 2'd1 : (op_i == ALU_SRA) ? 2'd2 : 2'd0;
    ctrl_d.cmp_fn    = (op_i == ALU_MSEQ) ? 2'd0 : 2'd1;
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ctrl_o <= '0;
    end else begin
      ctrl_o <= ctrl_d;
    end
  end

  // Lane split is meaningless with an unknown width
  a_ew_known: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    valid_i |-> !$isunknown(ew_i)
  );

endmodule

// File: hw/simd_alu_lane_exec.sv
/*
 * Stage 2 of the SIMD ALU
 * Per-lane widened add/subtract, compares, min/max, shifts and the logic word
 */
`timescale 1ns/1ns
`include "simd_alu_config.svh"

module simd_alu_lane_exec import simd_alu_pkg::*; (
  input  logic         clk_i,
  input  logic         arst_n_i,
  input  decode_ctrl_t ctrl_i,
  output exec_data_t   exec_o
);

  alu_word_u                   opa, opb;
  alu_word_u                   x_word, y_word;
  logic                        swap, left, arith;
  alu_wide_word_u              wide_sum;
  alu_word_u                   shift_res, minmax_res;
  logic [`SIMD_ALU_DATA_W-1:0] logic_res;
  logic [`SIMD_ALU_STRB_W-1:0] less, equal;
  logic [`SIMD_ALU_STRB_W-1:0] opa_sign, opb_sign;

  assign opa = ctrl_i.opa;
  assign opb = ctrl_i.opb;

  // Plain subtract is B - A, so swap the adder inputs
  assign swap   = ctrl_i.is_sub & ~ctrl_i.is_rsub;
  assign x_word = swap ? opb : opa;
  assign y_word = swap ? opa : opb;

  assign left  = ctrl_i.shift_fn == 2'd0;
  assign arith = ctrl_i.shift_fn == 2'd2;

  always_comb begin : p_logic
    unique case (ctrl_i.logic_fn)
      2'd1:    logic_res = opa | opb;
      2'd2:    logic_res = opa ^ opb;
      default: logic_res = opa & opb;
    endcase
  end

  always_comb begin : p_sign
    for (int i = 0; i < `SIMD_ALU_STRB_W; i++) begin
      opa_sign[i] = opa.w8[i][7];
      opb_sign[i] = opb.w8[i][7];
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Lane datapath
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin : p_lanes
    wide_sum   = '0;
    less       = '0;
    equal      = '0;
    shift_res  = '0;
    minmax_res = '0;

    unique case (ctrl_i.ew)
      EW8: for (int i = 0; i < 8; i++) begin
        wide_sum.w8.lane[i] = ctrl_i.is_sub ? {1'b0, x_word.w8[i]} - {1'b0, y_word.w8[i]}
                                            : {1'b0, x_word.w8[i]} + {1'b0, y_word.w8[i]};
        less[i]  = $signed({ctrl_i.is_signed & opb.w8[i][7], opb.w8[i]}) <
                   $signed({ctrl_i.is_signed & opa.w8[i][7], opa.w8[i]});
        equal[i] = opa.w8[i] == opb.w8[i];
        minmax_res.w8[i] = (less[i] ^ ctrl_i.pick_max) ? opb.w8[i] : opa.w8[i];
        shift_res.w8[i]  = left ? opb.w8[i] << opa.w8[i][2:0]
          : 8'({{8{arith & opb.w8[i][7]}}, opb.w8[i]} >> opa.w8[i][2:0]);
      end
      EW16: for (int i = 0; i < 4; i++) begin
        wide_sum.w16.lane[i] = ctrl_i.is_sub ? {1'b0, x_word.w16[i]} - {1'b0, y_word.w16[i]}
                                             : {1'b0, x_word.w16[i]} + {1'b0, y_word.w16[i]};
        less[2*i]  = $signed({ctrl_i.is_signed & opb.w16[i][15], opb.w16[i]}) <
                     $signed({ctrl_i.is_signed & opa.w16[i][15], opa.w16[i]});
        equal[2*i] = opa.w16[i] == opb.w16[i];
        minmax_res.w16[i] = (less[2*i] ^ ctrl_i.pick_max) ? opb.w16[i] : opa.w16[i];
        shift_res.w16[i]  = left ? opb.w16[i] << opa.w16[i][3:0]
          : 16'({{16{arith & opb.w16[i][15]}}, opb.w16[i]} >> opa.w16[i][3:0]);
      end
      EW32: for (int i = 0; i < 2; i++) begin
        wide_sum.w32.lane[i] = ctrl_i.is_sub ? {1'b0, x_word.w32[i]} - {1'b0, y_word.w32[i]}
                                             : {1'b0, x_word.w32[i]} + {1'b0, y_word.w32[i]};
        less[4*i]  = $signed({ctrl_i.is_signed & opb.w32[i][31], opb.w32[i]}) <
                     $signed({ctrl_i.is_signed & opa.w32[i][31], opa.w32[i]});
        equal[4*i] = opa.w32[i] == opb.w32[i];
        minmax_res.w32[i] = (less[4*i] ^ ctrl_i.pick_max) ? opb.w32[i] : opa.w32[i];
        shift_res.w32[i]  = left ? opb.w32[i] << opa.w32[i][4:0]
          : 32'({{32{arith & opb.w32[i][31]}}, opb.w32[i]} >> opa.w32[i][4:0]);
      end
      EW64: begin
        wide_sum.w64.lane[0] = ctrl_i.is_sub ? {1'b0, x_word.w64[0]} - {1'b0, y_word.w64[0]}
                                             : {1'b0, x_word.w64[0]} + {1'b0, y_word.w64[0]};
        less[0]  = $signed({ctrl_i.is_signed & opb.w64[0][63], opb.w64[0]}) <
                   $signed({ctrl_i.is_signed & opa.w64[0][63], opa.w64[0]});
        equal[0] = opa.w64[0] == opb.w64[0];
        minmax_res.w64[0] = (less[0] ^ ctrl_i.pick_max) ? opb.w64[0] : opa.w64[0];
        shift_res.w64[0]  = left ? opb.w64[0] << opa.w64[0][5:0]
          : 64'({{64{arith & opb.w64[0][63]}}, opb.w64[0]} >> opa.w64[0][5:0]);
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      exec_o <= '0;
    end else begin
      exec_o.valid      <= ctrl_i.valid;
      exec_o.ew         <= ctrl_i.ew;
      exec_o.res_sel    <= ctrl_i.res_sel;
      exec_o.sat_kind   <= ctrl_i.sat_kind;
      exec_o.logic_res  <= logic_res;
      exec_o.wide_sum   <= wide_sum;
      exec_o.shift_res  <= shift_res;
      exec_o.opa_sign   <= opa_sign;
      exec_o.opb_sign   <= opb_sign;
      exec_o.less       <= less;
      exec_o.equal      <= equal;
      exec_o.minmax_res <= minmax_res;
      exec_o.cmp_fn     <= ctrl_i.cmp_fn;
    end
  end

endmodule

// File: hw/simd_alu_pkg.sv
/*
 * Types of the SIMD ALU: operation and width codes,
 * lane views of a word and the per-stage pipeline structs
 */
`include "simd_alu_config.svh"

package simd_alu_pkg;

  typedef enum logic [4:0] {
    ALU_AND, ALU_OR, ALU_XOR,
    ALU_ADD, ALU_SUB, ALU_RSUB,
    ALU_SADDU, ALU_SADD, ALU_SSUBU, ALU_SSUB,
    ALU_SLL, ALU_SRL, ALU_SRA,
    ALU_MIN, ALU_MINU, ALU_MAX, ALU_MAXU,
    ALU_MSEQ, ALU_MSLT, ALU_MSLTU
  } alu_op_e;

  typedef enum logic [1:0] {EW8, EW16, EW32, EW64} elem_width_e;

  typedef union packed {
    logic [0:0][`SIMD_ALU_DATA_W-1:0]   w64;
    logic [1:0][`SIMD_ALU_DATA_W/2-1:0] w32;
    logic [3:0][`SIMD_ALU_DATA_W/4-1:0] w16;
    logic [7:0][`SIMD_ALU_DATA_W/8-1:0] w8;
  } alu_word_u;

  // Lane results with one extra carry bit, padded to 72 bits
  typedef struct packed {
    logic [6:0]       pad;
    logic [0:0][64:0] lane;
  } wide_w64_t;

  typedef struct packed {
    logic [5:0]       pad;
    logic [1:0][32:0] lane;
  } wide_w32_t;

  typedef struct packed {
    logic [3:0]       pad;
    logic [3:0][16:0] lane;
  } wide_w16_t;

  typedef struct packed {
    logic [7:0][8:0] lane;
  } wide_w8_t;

  typedef union packed {
    wide_w64_t w64;
    wide_w32_t w32;
    wide_w16_t w16;
    wide_w8_t  w8;
  } alu_wide_word_u;

  typedef enum logic [2:0] {SEL_LOGIC, SEL_ARITH, SEL_SHIFT, SEL_MINMAX, SEL_CMP} res_sel_e;

  typedef enum logic [2:0] {SAT_NONE, SAT_UADD, SAT_SADD, SAT_USUB, SAT_SSUB} sat_kind_e;

  // logic_fn 0 and, 1 or, 2 xor; shift_fn 0 sll, 1 srl, 2 sra; cmp_fn 0 eq, 1 lt
  typedef struct packed {
    logic        valid;
    elem_width_e ew;
    alu_word_u   opa;
    alu_word_u   opb;
    res_sel_e    res_sel;
    sat_kind_e   sat_kind;
    logic        is_signed;
    logic        is_sub;
    logic        is_rsub;
    logic [1:0]  logic_fn;
    logic [1:0]  shift_fn;
    logic        pick_max;
    logic [1:0]  cmp_fn;
  } decode_ctrl_t;

  typedef struct packed {
    logic                         valid;
    elem_width_e                  ew;
    res_sel_e                     res_sel;
    sat_kind_e                    sat_kind;
    logic [`SIMD_ALU_DATA_W-1:0]  logic_res;
    alu_wide_word_u               wide_sum;
    alu_word_u                    shift_res;
    logic [`SIMD_ALU_STRB_W-1:0]  opa_sign;
    logic [`SIMD_ALU_STRB_W-1:0]  opb_sign;
    logic [`SIMD_ALU_STRB_W-1:0]  less;
    logic [`SIMD_ALU_STRB_W-1:0]  equal;
    alu_word_u                    minmax_res;
    logic [1:0]                   cmp_fn;
  } exec_data_t;

endpackage

// File: hw/simd_alu_result.sv
/*
 * Stage 3 of the SIMD ALU
 * Result select, per-lane saturation and compare lanes
 */
`timescale 1ns/1ns
`include "simd_alu_config.svh"

module simd_alu_result import simd_alu_pkg::*; (
  input  logic                        clk_i,
  input  logic                        arst_n_i,
  input  exec_data_t                  exec_i,
  output logic                        valid_o,
  output alu_word_u                   result_o,
  output logic [`SIMD_ALU_STRB_W-1:0] vxsat_o
);

  alu_wide_word_u              wide;
  logic [`SIMD_ALU_STRB_W-1:0] cmp_vec;
  alu_word_u                   result_d;
  logic [`SIMD_ALU_STRB_W-1:0] vxsat_d;

  assign wide    = exec_i.wide_sum;
  assign cmp_vec = (exec_i.cmp_fn == 2'd0) ? exec_i.equal : exec_i.less;

  // Returns {saturated, clamp msb, clamp remaining bits}
  function automatic logic [2:0] sat_check(sat_kind_e kind, logic carry, logic msb,
                                           logic sa, logic sb);
    logic neg;
    neg = (kind == SAT_SADD) ? sa : sb;
    unique case (kind)
      SAT_UADD: sat_check = {carry, 2'b11};
      SAT_USUB: sat_check = {carry, 2'b00};
      SAT_SADD: sat_check = {(sa == sb) & (msb != sa), neg, ~neg};
      SAT_SSUB: sat_check = {(sa != sb) & (msb != sb), neg, ~neg};
      default:  sat_check = 3'b000;
    endcase
  endfunction

  always_comb begin : p_result
    logic [2:0] chk;
    chk      = '0;
    result_d = '0;
    vxsat_d  = '0;

    if (exec_i.valid) begin
      unique case (exec_i.res_sel)
        SEL_LOGIC:  result_d = exec_i.logic_res;
        SEL_SHIFT:  result_d = exec_i.shift_res;
        SEL_MINMAX: result_d = exec_i.minmax_res;
        SEL_CMP: unique case (exec_i.ew)
          EW8:  for (int i = 0; i < 8; i++) result_d.w8[i] = 8'(cmp_vec[i]);
          EW16: for (int i = 0; i < 4; i++) result_d.w16[i] = 16'(cmp_vec[2*i]);
          EW32: for (int i = 0; i < 2; i++) result_d.w32[i] = 32'(cmp_vec[4*i]);
          EW64: result_d.w64[0] = 64'(cmp_vec[0]);
        endcase
        default: unique case (exec_i.ew)
          EW8: for (int i = 0; i < 8; i++) begin
            chk = sat_check(exec_i.sat_kind, wide.w8.lane[i][8], wide.w8.lane[i][7],
                            exec_i.opa_sign[i], exec_i.opb_sign[i]);
            result_d.w8[i] = chk[2] ? {chk[1], {7{chk[0]}}} : wide.w8.lane[i][7:0];
            vxsat_d[i]     = chk[2];
          end
          EW16: for (int i = 0; i < 4; i++) begin
            chk = sat_check(exec_i.sat_kind, wide.w16.lane[i][16], wide.w16.lane[i][15],
                            exec_i.opa_sign[2*i+1], exec_i.opb_sign[2*i+1]);
            result_d.w16[i]   = chk[2] ? {chk[1], {15{chk[0]}}} : wide.w16.lane[i][15:0];
            vxsat_d[2*i +: 2] = {2{chk[2]}};
          end
          EW32: for (int i = 0; i < 2; i++) begin
            chk = sat_check(exec_i.sat_kind, wide.w32.lane[i][32], wide.w32.lane[i][31],
                            exec_i.opa_sign[4*i+3], exec_i.opb_sign[4*i+3]);
            result_d.w32[i]   = chk[2] ? {chk[1], {31{chk[0]}}} : wide.w32.lane[i][31:0];
            vxsat_d[4*i +: 4] = {4{chk[2]}};
          end
          EW64: begin
            chk = sat_check(exec_i.sat_kind, wide.w64.lane[0][64], wide.w64.lane[0][63],
                            exec_i.opa_sign[7], exec_i.opb_sign[7]);
            result_d.w64[0] = chk[2] ? {chk[1], {63{chk[0]}}} : wide.w64.lane[0][63:0];
            vxsat_d         = {8{chk[2]}};
          end
        endcase
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_o  <= 1'b0;
      result_o <= '0;
      vxsat_o  <= '0;
    end else begin
      valid_o  <= exec_i.valid;
      result_o <= result_d;
      vxsat_o  <= vxsat_d;
    end
  end

  // Non-saturating ops never raise a flag one cycle later
  a_no_sat_flag: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    exec_i.sat_kind == SAT_NONE |=> vxsat_o == '0
  );

endmodule

// File: hw/simd_alu_top.sv
/*
 * Top level of the SIMD ALU
 * Decode, lane execute and result stages, three cycles end to end
 */
`timescale 1ns/1ns
`include "simd_alu_config.svh"

module simd_alu_top import simd_alu_pkg::*; (
  input  logic                        clk_i,
  input  logic                        arst_n_i,
  input  logic                        valid_i,
  input  alu_op_e                     op_i,
  input  elem_width_e                 ew_i,
  input  alu_word_u                   operand_a_i,
  input  alu_word_u                   operand_b_i,
  output logic                        valid_o,
  output alu_word_u                   result_o,
  output logic [`SIMD_ALU_STRB_W-1:0] vxsat_o
);

  decode_ctrl_t ctrl;
  exec_data_t   exec;

  simd_alu_decode u_decode (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .valid_i     (valid_i),
    .op_i        (op_i),
    .ew_i        (ew_i),
    .operand_a_i (operand_a_i),
    .operand_b_i (operand_b_i),
    .ctrl_o      (ctrl)
  );

  simd_alu_lane_exec u_lane_exec (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .ctrl_i   (ctrl),
    .exec_o   (exec)
  );

  simd_alu_result u_result (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .exec_i   (exec),
    .valid_o  (valid_o),
    .result_o (result_o),
    .vxsat_o  (vxsat_o)
  );

endmodule

// File: run.sh
#!/bin/sh
# Build and run the SIMD ALU testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module tb_simd_alu -f sources.f -o tb_simd_alu

./obj_dir/tb_simd_alu > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log

if grep -q "ALL TESTS PASSED" sim.log; then
  exit 0
fi
exit 1

// File: sources.f
+incdir+hw
+incdir+test
hw/simd_alu_pkg.sv
hw/simd_alu_decode.sv
hw/simd_alu_lane_exec.sv
hw/simd_alu_result.sv
hw/simd_alu_top.sv
test/tb_simd_alu.sv

// File: test/tb_simd_alu_ref.svh
/*
 * Testbench helpers of the SIMD ALU
 * Lane reference model, Galois LFSR and the expected-result queue
 */
`ifndef TB_SIMD_ALU_REF_SVH
`define TB_SIMD_ALU_REF_SVH

typedef struct packed {
  logic [`SIMD_ALU_DATA_W-1:0] res;
  logic [`SIMD_ALU_STRB_W-1:0] sat;
} expect_t;

expect_t     exp_q[$];
logic [31:0] lfsr_state = 32'h9eff_c1d5;

// One LFSR step per bit taken
function automatic logic [63:0] rand_word();
  logic [63:0] v;
  v = '0;
  for (int i = 0; i < 64; i++) begin
    lfsr_state = {1'b0, lfsr_state[31:1]} ^ (lfsr_state[0] ? 32'h8020_0003 : 32'h0);
    v = {v[62:0], lfsr_state[0]};
  end
  return v;
endfunction

function automatic logic [63:0] lane_mask(elem_width_e ew);
  int unsigned w;
  w = 8 << ew;
  return (w == 64) ? '1 : (64'd1 << w) - 64'd1;
endfunction

// Copies the low lane of v into every lane
function automatic logic [63:0] lane_fill(elem_width_e ew, logic [63:0] v);
  logic [63:0] f;
  int unsigned w;
  w = 8 << ew;
  f = '0;
  for (int unsigned l = 0; l < 64 / w; l++) begin
    f = f | ((v & lane_mask(ew)) << (l * w));
  end
  return f;
endfunction

// 0, 1, largest positive, most negative, all ones
function automatic logic [63:0] edge_val(elem_width_e ew, int k);
  logic [63:0] m;
  m = lane_mask(ew);
  case (k)
    0:       return 64'd0;
    1:       return 64'd1;
    2:       return m >> 1;
    3:       return ~(m >> 1) & m;
    default: return m;
  endcase
endfunction

function automatic logic signed [65:0] sext(logic [63:0] v, logic [63:0] m);
  if ((v & ~(m >> 1)) != 64'd0) begin
    return $signed({2'b11, v | ~m});
  end
  return $signed({2'b00, v});
endfunction

function automatic expect_t model_op(alu_op_e op, elem_width_e ew,
                                     logic [63:0] a, logic [63:0] b);
  int unsigned        w;
  int                 sh;
  logic [63:0]        m, la, lb, r, smax;
  logic [64:0]        u;
  logic signed [65:0] sa, sb, s, s_hi, s_lo;
  logic [7:0]         bm;
  logic               sat;
  expect_t            e;
  w    = 8 << ew;
  m    = lane_mask(ew);
  smax = m >> 1;
  s_hi = sext(smax, m);
  s_lo = sext(~smax & m, m);
  bm   = 8'((16'd1 << (w / 8)) - 16'd1);
  e    = '0;
  for (int unsigned l = 0; l < 64 / w; l++) begin
    la  = (a >> (l * w)) & m;
    lb  = (b >> (l * w)) & m;
    sa  = sext(la, m);
    sb  = sext(lb, m);
    sh  = int'(la[5:0] & 6'(w - 1));
    sat = 1'b0;
    case (op)
      ALU_AND:  r = la & lb;
      ALU_OR:   r = la | lb;
      ALU_XOR:  r = la ^ lb;
      ALU_ADD:  r = la + lb;
      ALU_SUB:  r = lb - la;
      ALU_RSUB: r = la - lb;
      ALU_SADDU: begin
        u   = {1'b0, la} + {1'b0, lb};
        sat = u > {1'b0, m};
        r   = sat ? m : u[63:0];
      end
      ALU_SSUBU: begin
        sat = lb < la;
        r   = sat ? 64'd0 : lb - la;
      end
      ALU_SADD, ALU_SSUB: begin
        s   = (op == ALU_SADD) ? sb + sa : sb - sa;
        sat = (s > s_hi) || (s < s_lo);
        r   = (s > s_hi) ? smax : (s < s_lo) ? ~smax : s[63:0];
      end
      ALU_SLL:   r = lb << sh;
      ALU_SRL:   r = lb >> sh;
      ALU_SRA:   r = 64'(sb >>> sh);
      ALU_MIN:   r = (sb < sa) ? lb : la;
      ALU_MINU:  r = (lb < la) ? lb : la;
      ALU_MAX:   r = (sb < sa) ? la : lb;
      ALU_MAXU:  r = (lb < la) ? la : lb;
      ALU_MSEQ:  r = 64'(lb == la);
      ALU_MSLT:  r = 64'(sb < sa);
      ALU_MSLTU: r = 64'(lb < la);
      default:   r = 64'd0;
    endcase
    e.res = e.res | ((r & m) << (l * w));
    if (sat) begin
      e.sat = e.sat | (bm << (l * (w / 8)));
    end
  end
  return e;
endfunction

`endif

// File: test/tb_simd_alu.sv
/*
 * Testbench of the SIMD ALU
 * Clock, reset, directed and LFSR stimulus, output assertions and report
 */
`timescale 1ns/1ns
`include "simd_alu_config.svh"

module tb_simd_alu import simd_alu_pkg::*; ();

  logic                         clk_i;
  logic                         arst_n_i;
  logic                         valid_i;
  alu_op_e                      op_i;
  elem_width_e                  ew_i;
  alu_word_u                    operand_a_i;
  alu_word_u                    operand_b_i;
  logic                         valid_o;
  alu_word_u                    result_o;
  logic [`SIMD_ALU_STRB_W-1:0]  vxsat_o;

  logic [`SIMD_ALU_LATENCY-1:0] valid_hist;
  int                           err_cnt;
  int                           check_cnt;
  int                           test_cnt;
  int                           test_fail_cnt;

`include "tb_simd_alu_ref.svh"

  expect_t exp_cur;

  always #5 clk_i = ~clk_i;

  simd_alu_top u_simd_alu_top (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .valid_i     (valid_i),
    .op_i        (op_i),
    .ew_i        (ew_i),
    .operand_a_i (operand_a_i),
    .operand_b_i (operand_b_i),
    .valid_o     (valid_o),
    .result_o    (result_o),
    .vxsat_o     (vxsat_o)
  );

  task automatic report_mismatch(string name, logic [63:0] got, logic [63:0] exp);
    $display("Mismatch %s: got %h, expected %h at %0t", name, got, exp, $time);
    err_cnt++;
  endtask

  // Expected head advances with the output stage
  always @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_hist <= '0;
      exp_cur    <= '0;
    end else begin
      valid_hist <= {valid_hist[`SIMD_ALU_LATENCY-2:0], valid_i};
      if (valid_hist[`SIMD_ALU_LATENCY-2]) begin
        if (exp_q.size() != 0) begin
          exp_cur <= exp_q.pop_front();
        end else begin
          $display("Result due with no operation in the expected queue at %0t", $time);
          err_cnt++;
        end
      end
    end
  end

  always @(negedge clk_i) begin
    if (arst_n_i && valid_o) begin
      check_cnt++;
    end
  end

  a_latency: assert property (@(negedge clk_i) disable iff (!arst_n_i)
    valid_o == valid_hist[`SIMD_ALU_LATENCY-1])
    else report_mismatch("valid_o", 64'(valid_o), 64'(valid_hist[`SIMD_ALU_LATENCY-1]));

  // Zero outputs while idle
  a_result: assert property (@(negedge clk_i) disable iff (!arst_n_i)
    result_o == (valid_hist[`SIMD_ALU_LATENCY-1] ? exp_cur.res : 64'd0))
    else report_mismatch("result_o", result_o,
                         valid_hist[`SIMD_ALU_LATENCY-1] ? exp_cur.res : 64'd0);

  a_vxsat: assert property (@(negedge clk_i) disable iff (!arst_n_i)
    vxsat_o == (valid_hist[`SIMD_ALU_LATENCY-1] ? exp_cur.sat : 8'd0))
    else report_mismatch("vxsat_o", 64'(vxsat_o),
                         64'(valid_hist[`SIMD_ALU_LATENCY-1] ? exp_cur.sat : 8'd0));

  task automatic issue(alu_op_e op, elem_width_e ew, logic [63:0] a, logic [63:0] b);
    @(negedge clk_i);
    valid_i     = 1'b1;
    op_i        = op;
    ew_i        = ew;
    operand_a_i = a;
    operand_b_i = b;
    exp_q.push_back(model_op(op, ew, a, b));
  endtask

  task automatic issue_rand(alu_op_e op, elem_width_e ew);
    logic [63:0] a;
    logic [63:0] b;
    a = rand_word();
    b = rand_word();
    issue(op, ew, a, b);
  endtask

  task automatic drain();
    int n;
    @(negedge clk_i);
    valid_i = 1'b0;
    n = 0;
    while (exp_q.size() != 0 && n < 20) begin
      @(posedge clk_i);
      n++;
    end
    if (exp_q.size() != 0) begin
      $display("Timeout: %0d results never came out of the pipeline", exp_q.size());
      err_cnt++;
      exp_q.delete();
    end
    // One more cycle so the last output check has run
    repeat (2) @(negedge clk_i);
  endtask

  task automatic end_test(string name, int err_before);
    test_cnt++;
    if (err_cnt == err_before) begin
      $display("Test %s: ok", name);
    end else begin
      test_fail_cnt++;
      $display("Test %s: %0d errors", name, err_cnt - err_before);
    end
  endtask

  initial begin : p_main
    int          e0;
    elem_width_e ew;
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] sm;
    clk_i       = 1'b0;
    arst_n_i    = 1'b0;
    valid_i     = 1'b0;
    op_i        = ALU_AND;
    ew_i        = EW8;
    operand_a_i = '0;
    operand_b_i = '0;
    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    arst_n_i = 1'b1;

    // Single op, then a back-to-back burst
    e0 = err_cnt;
    issue(ALU_ADD, EW8, 64'h0102_0304_0506_0708, 64'h1010_1010_1010_1010);
    drain();
    issue_rand(ALU_XOR, EW64);
    issue_rand(ALU_SUB, EW16);
    issue_rand(ALU_MAXU, EW32);
    issue_rand(ALU_MSEQ, EW8);
    drain();
    end_test("pipeline", e0);

    e0 = err_cnt;
    for (int k = 0; k < 4; k++) begin
      for (int o = ALU_AND; o <= ALU_XOR; o++) begin
        repeat (4) issue_rand(alu_op_e'(o), elem_width_e'(k));
      end
    end
    drain();
    end_test("logic", e0);

    e0 = err_cnt;
    for (int k = 0; k < 4; k++) begin
      ew = elem_width_e'(k);
      for (int o = ALU_ADD; o <= ALU_RSUB; o++) begin
        repeat (6) issue_rand(alu_op_e'(o), ew);
        issue(alu_op_e'(o), ew, lane_fill(ew, edge_val(ew, 4)), lane_fill(ew, 64'd1));
        issue(alu_op_e'(o), ew, lane_fill(ew, 64'd1), 64'd0);
      end
    end
    drain();
    end_test("wrap", e0);

    // Every pair of lane edge values
    e0 = err_cnt;
    for (int k = 0; k < 4; k++) begin
      ew = elem_width_e'(k);
      for (int o = ALU_SADDU; o <= ALU_SSUB; o++) begin
        for (int i = 0; i < 5; i++) begin
          for (int j = 0; j < 5; j++) begin
            issue(alu_op_e'(o), ew, lane_fill(ew, edge_val(ew, i)),
                  lane_fill(ew, edge_val(ew, j)));
          end
        end
        repeat (4) issue_rand(alu_op_e'(o), ew);
      end
    end
    drain();
    end_test("saturate", e0);

    e0 = err_cnt;
    for (int k = 0; k < 4; k++) begin
      ew = elem_width_e'(k);
      sm = lane_fill(ew, edge_val(ew, 3));
      for (int o = ALU_SLL; o <= ALU_SRA; o++) begin
        repeat (6) issue_rand(alu_op_e'(o), ew);
        issue(alu_op_e'(o), ew, '1, rand_word() | sm);
      end
    end
    drain();
    end_test("shift", e0);

    // Sign bits differ so signed and unsigned outcomes split
    e0 = err_cnt;
    for (int k = 0; k < 4; k++) begin
      ew = elem_width_e'(k);
      sm = lane_fill(ew, edge_val(ew, 3));
      for (int o = ALU_MIN; o <= ALU_MSLTU; o++) begin
        repeat (2) begin
          a = rand_word() | sm;
          b = rand_word() & ~sm;
          issue(alu_op_e'(o), ew, a, b);
          issue(alu_op_e'(o), ew, b, a);
          issue(alu_op_e'(o), ew, a, a);
        end
      end
    end
    drain();
    end_test("minmax_cmp", e0);

    $display("Tests %0d, failed %0d, output checks %0d, errors %0d",
             test_cnt, test_fail_cnt, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  initial begin : p_watchdog
    #200_000;
    $display("Timeout: simulation did not reach the end of the test sequence");
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule
